//--- include/svision_defs.svh
`ifndef SVISION_DEFS_SVH
`define SVISION_DEFS_SVH

// word address width of the cartridge ROM, 32K words
`define ROM_AW 15

// sample width of the core's audio channels
`define DAC_BITS 4

// PS/2 set-2 scan codes for the player controls
`define KEY_UP     8'h75
`define KEY_DOWN   8'h72
`define KEY_LEFT   8'h6B
`define KEY_RIGHT  8'h74
`define KEY_FIRE_A 8'h14 // ctrl
`define KEY_FIRE_B 8'h11 // alt
`define KEY_FIRE_C 8'h29 // space
`define KEY_FIRE_D 8'h12 // left shift

`endif

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_svision_platform -f sources.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

//--- sources.f
+incdir+include
verilog/mem_pkg.sv
verilog/input_pkg.sv
verilog/rom_loader.sv
verilog/rom_store.sv
verilog/input_mapper.sv
verilog/sigma_delta_dac.sv
verilog/svision_platform.sv
tb/svision_asserts.sv
tb/tb_svision_platform.sv

//--- tb/svision_asserts.sv
`timescale 1ns/1ps

module svision_asserts (
	input logic                       clk_sys,
	input logic                       rst_n,
	input logic                       ioctl_download,
	input logic                       mem_we,
	input logic                       rom_loaded,
	input logic                       core_reset,
	input input_pkg::player_buttons_t player_buttons
);
	import input_pkg::*;

	int fail_count = 0;

	// a ROM write is the registered copy of a strobe seen during the download
	property write_inside_download;
		@(posedge clk_sys) disable iff (!rst_n)
			mem_we |-> (ioctl_download || $past(ioctl_download));
	endproperty

	property core_held_until_loaded;
		@(posedge clk_sys) disable iff (!rst_n)
			!rom_loaded |-> core_reset;
	endproperty

	// only a board reset may clear the loaded flag
	property loaded_is_sticky;
		@(posedge clk_sys) disable iff (!rst_n)
			$fell(rom_loaded) |-> !$past(rst_n);
	endproperty

	property buttons_known;
		@(posedge clk_sys) disable iff (!rst_n)
			!$isunknown(player_buttons);
	endproperty

	assert property (write_inside_download) else begin
		fail_count++;
		$error("ROM write outside a download");
	end
	assert property (core_held_until_loaded) else begin
		fail_count++;
		$error("core left reset before the ROM loaded");
	end
	assert property (loaded_is_sticky) else begin
		fail_count++;
		$error("rom_loaded fell without a reset");
	end
	assert property (buttons_known) else begin
		fail_count++;
		$error("player_buttons has unknown bits");
	end

endmodule

bind svision_platform svision_asserts checks (
	.clk_sys        (clk_sys),
	.rst_n          (rst_n),
	.ioctl_download (ioctl_download),
	.mem_we         (mem_we),
	.rom_loaded     (rom_loaded),
	.core_reset     (core_reset),
	.player_buttons (player_buttons)
);

//--- tb/tb_svision_platform.sv
`timescale 1ns/1ps
`include "svision_defs.svh"

module tb_svision_platform;
	import input_pkg::*;

	localparam int max_tests  = 256;
	localparam int k_download = 0;
	localparam int k_read     = 1;
	localparam int k_key      = 2;
	localparam int k_joy      = 3;
	localparam int k_audio    = 4;
	localparam int k_reset    = 5;
	localparam logic [31:0] rom_base = 32'h0000_0200;

	logic                 clk_sys;
	logic                 rst_n;
	logic                 ioctl_download;
	logic                 ioctl_wr;
	logic [24:0]          ioctl_addr;
	logic [7:0]           ioctl_dout;
	logic                 menu_reset;
	logic                 button_reset;
	logic [15:0]          cpu_rom_addr;
	logic                 key_strobe;
	logic                 key_pressed;
	key_code_t            key_code;
	joy_word_t            joystick_0;
	joy_word_t            joystick_1;
	logic                 joyswap;
	logic [`DAC_BITS-1:0] audio_ch1;
	logic [`DAC_BITS-1:0] audio_ch2;
	logic [7:0]           cpu_rom_data;
	logic                 rom_loaded;
	logic                 core_reset;
	player_buttons_t      player_buttons;
	logic                 audio_l;
	logic                 audio_r;

	string       t_name [max_tests];
	int          t_kind [max_tests];
	logic [31:0] t_addr [max_tests];
	logic [31:0] t_value [max_tests];
	logic [31:0] t_expect [max_tests];
	logic [7:0]  rom_image [64]; // bytes the host sent, in address order
	int          n_tests;
	int          seed;
	int          cycle_count;
	int          cycle_limit = 0;
	int          passed;
	int          failed;
	logic        test_failed;
	logic        download_active;

	svision_platform UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// cycles each kind of entry takes, used for the run limit
	function automatic int cost_of(input int kind);
		case (kind)
			k_download: return 2;
			k_key:      return 2;
			k_audio:    return 16;
			default:    return 1;
		endcase
	endfunction

	task automatic add_entry(input string name, input int kind, input logic [31:0] addr,
			input logic [31:0] value, input logic [31:0] expected);
		t_name[n_tests]   = name;
		t_kind[n_tests]   = kind;
		t_addr[n_tests]   = addr;
		t_value[n_tests]  = value;
		t_expect[n_tests] = expected;
		n_tests++;
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		for (int i = 0; i < 64; i++) begin
			rnd = $random(seed);
			rom_image[i] = rnd[7:0];
			// the core stays in reset while bytes arrive
			add_entry($sformatf("download %0d", i), k_download, rom_base + i,
				{24'h0, rnd[7:0]}, 32'h1);
		end
		for (int i = 0; i < 64; i++) begin
			add_entry($sformatf("read %0d", i), k_read, rom_base + i, 32'h0, {24'h0, rom_image[i]});
		end
		add_entry("menu reset on", k_reset, 32'h0, 32'h1, 32'h1);
		add_entry("menu reset off", k_reset, 32'h0, 32'h0, 32'h0);
		add_entry("button reset on", k_reset, 32'h1, 32'h1, 32'h1);
		add_entry("button reset off", k_reset, 32'h1, 32'h0, 32'h0);
		add_entry("press up", k_key, {24'h0, `KEY_UP}, 32'h1, 32'h08);
		add_entry("press down", k_key, {24'h0, `KEY_DOWN}, 32'h1, 32'h0C);
		add_entry("press left", k_key, {24'h0, `KEY_LEFT}, 32'h1, 32'h0E);
		add_entry("press right", k_key, {24'h0, `KEY_RIGHT}, 32'h1, 32'h0F);
		add_entry("press fire a", k_key, {24'h0, `KEY_FIRE_A}, 32'h1, 32'h8F);
		add_entry("press fire b", k_key, {24'h0, `KEY_FIRE_B}, 32'h1, 32'hCF);
		add_entry("press fire c", k_key, {24'h0, `KEY_FIRE_C}, 32'h1, 32'hEF);
		add_entry("press fire d", k_key, {24'h0, `KEY_FIRE_D}, 32'h1, 32'hFF);
		add_entry("release unknown key", k_key, 32'h1C, 32'h0, 32'hFF);
		add_entry("release up", k_key, {24'h0, `KEY_UP}, 32'h0, 32'hF7);
		add_entry("release down", k_key, {24'h0, `KEY_DOWN}, 32'h0, 32'hF3);
		add_entry("release left", k_key, {24'h0, `KEY_LEFT}, 32'h0, 32'hF1);
		add_entry("release right", k_key, {24'h0, `KEY_RIGHT}, 32'h0, 32'hF0);
		add_entry("release fire a", k_key, {24'h0, `KEY_FIRE_A}, 32'h0, 32'h70);
		add_entry("release fire b", k_key, {24'h0, `KEY_FIRE_B}, 32'h0, 32'h30);
		add_entry("release fire c", k_key, {24'h0, `KEY_FIRE_C}, 32'h0, 32'h10);
		add_entry("release fire d", k_key, {24'h0, `KEY_FIRE_D}, 32'h0, 32'h00);
		// addr bit 0 picks the joystick to load, addr bit 1 is joyswap
		add_entry("joy0 right fire a", k_joy, 32'h0, 32'hFFFF_FF11, 32'h81);
		add_entry("joy0 down fire b d", k_joy, 32'h0, 32'h0000_00A4, 32'h54);
		add_entry("joy1 loaded unselected", k_joy, 32'h1, 32'h0000_0048, 32'h54);
		add_entry("press left with joy0", k_key, {24'h0, `KEY_LEFT}, 32'h1, 32'h56);
		add_entry("joyswap to joy1", k_joy, 32'h3, 32'h0000_0048, 32'h2A);
		add_entry("joyswap back to joy0", k_joy, 32'h0, 32'h0000_00A4, 32'h56);
		add_entry("release left with joy0", k_key, {24'h0, `KEY_LEFT}, 32'h0, 32'h54);
		add_entry("joy0 cleared", k_joy, 32'h0, 32'h0, 32'h00);
		add_entry("audio 0", k_audio, 32'h0, 32'd0, 32'd0);
		add_entry("audio 5", k_audio, 32'h0, 32'd5, 32'd5);
		add_entry("audio 11", k_audio, 32'h0, 32'd11, 32'd11);
		add_entry("audio 15", k_audio, 32'h0, 32'd15, 32'd15);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Error %s: expected %0h, actual %0h", name, expected, actual);
			test_failed = 1'b1;
		end
	endtask

	task automatic close_test(input string name);
		if (test_failed) begin
			failed++;
			$display("[failed] %s", name);
		end else begin
			passed++;
			$display("[ok] %s", name);
		end
	endtask

	// end of the image, the core leaves reset two cycles later
	task automatic finish_download();
		test_failed = 1'b0;
		ioctl_download = 1'b0;
		download_active = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_value("download end rom_loaded", 32'h1, {31'h0, rom_loaded});
		check_value("download end core_reset", 32'h0, {31'h0, core_reset});
		close_test("download end");
	endtask

	task automatic apply_entry(input int idx);
		int ones_l;
		int ones_r;
		case (t_kind[idx])
			k_download: begin
				ioctl_download = 1'b1;
				download_active = 1'b1;
				ioctl_wr = 1'b1;
				ioctl_addr = t_addr[idx][24:0];
				ioctl_dout = t_value[idx][7:0];
				@(negedge clk_sys);
				ioctl_wr = 1'b0; // strobes keep one idle cycle between them
				@(negedge clk_sys);
				check_value(t_name[idx], t_expect[idx], {31'h0, core_reset});
			end
			k_read: begin
				cpu_rom_addr = t_addr[idx][15:0];
				@(negedge clk_sys);
				check_value(t_name[idx], t_expect[idx], {24'h0, cpu_rom_data});
			end
			k_key: begin
				key_strobe = 1'b1;
				key_pressed = t_value[idx][0];
				key_code = t_addr[idx][7:0];
				@(negedge clk_sys);
				key_strobe = 1'b0;
				@(negedge clk_sys);
				check_value(t_name[idx], t_expect[idx], {24'h0, player_buttons});
			end
			k_joy: begin
				if (t_addr[idx][0]) begin
					joystick_1 = t_value[idx];
				end else begin
					joystick_0 = t_value[idx];
				end
				joyswap = t_addr[idx][1];
				@(negedge clk_sys);
				check_value(t_name[idx], t_expect[idx], {24'h0, player_buttons});
			end
			k_reset: begin
				if (t_addr[idx][0]) begin
					button_reset = t_value[idx][0];
				end else begin
					menu_reset = t_value[idx][0];
				end
				@(negedge clk_sys);
				check_value(t_name[idx], t_expect[idx], {31'h0, core_reset});
			end
			k_audio: begin
				audio_ch1 = t_value[idx][`DAC_BITS-1:0];
				audio_ch2 = t_value[idx][`DAC_BITS-1:0];
				ones_l = 0;
				ones_r = 0;
				repeat (16) begin // every sample here comes from an add of the new value
					@(negedge clk_sys);
					if (audio_l) ones_l++;
					if (audio_r) ones_r++;
				end
				check_value({t_name[idx], " left"}, t_expect[idx], ones_l);
				check_value({t_name[idx], " right"}, t_expect[idx], ones_r);
			end
			default: begin
				$display("entry %s has an unknown kind %0d", t_name[idx], t_kind[idx]);
				test_failed = 1'b1;
			end
		endcase
	endtask

	initial begin
		int total;
		seed = 31853;
		n_tests = 0;
		passed = 0;
		failed = 0;
		download_active = 1'b0;
		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		menu_reset = 1'b0;
		button_reset = 1'b0;
		cpu_rom_addr = '0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		joyswap = 1'b0;
		audio_ch1 = '0;
		audio_ch2 = '0;
		build_table();
		total = 5 + 50;
		for (int i = 0; i < n_tests; i++) begin
			total += cost_of(t_kind[i]);
		end
		cycle_limit = total;
		repeat (5) @(negedge clk_sys);
		rst_n = 1'b1;
		test_failed = 1'b0;
		check_value("reset core_reset", 32'h1, {31'h0, core_reset});
		check_value("reset rom_loaded", 32'h0, {31'h0, rom_loaded});
		check_value("reset player_buttons", 32'h0, {24'h0, player_buttons});
		check_value("reset audio_l", 32'h0, {31'h0, audio_l});
		check_value("reset audio_r", 32'h0, {31'h0, audio_r});
		close_test("reset values");
		for (int i = 0; i < n_tests; i++) begin
			if (download_active && t_kind[i] != k_download) begin
				finish_download();
			end
			test_failed = 1'b0;
			apply_entry(i);
			close_test(t_name[i]);
		end
		$display("tests run: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
			passed + failed, passed, failed, UUT.checks.fail_count);
		if (failed == 0 && UUT.checks.fail_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("simulation timed out after %0d cycles", cycle_count);
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- verilog/input_mapper.sv
`timescale 1ns/1ps
`include "svision_defs.svh"

module input_mapper (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        key_strobe,
	input  logic                        key_pressed,
	input  input_pkg::key_code_t        key_code,
	input  input_pkg::joy_word_t        joystick_0,
	input  input_pkg::joy_word_t        joystick_1,
	input  logic                        joyswap,
	output input_pkg::player_buttons_t  player_buttons
);
	import input_pkg::*;

	player_buttons_t key_state;
	player_buttons_t joy_buttons;
	joy_word_t       sel_joy;

	// key bits are held in the same layout as the player buttons
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			key_state <= '0;
		end else if (key_strobe) begin
			case (key_code)
				`KEY_UP:     key_state[btn_up]     <= key_pressed;
				`KEY_DOWN:   key_state[btn_down]   <= key_pressed;
				`KEY_LEFT:   key_state[btn_left]   <= key_pressed;
				`KEY_RIGHT:  key_state[btn_right]  <= key_pressed;
				`KEY_FIRE_A: key_state[btn_fire_a] <= key_pressed;
				`KEY_FIRE_B: key_state[btn_fire_b] <= key_pressed;
				`KEY_FIRE_C: key_state[btn_fire_c] <= key_pressed;
				`KEY_FIRE_D: key_state[btn_fire_d] <= key_pressed;
				default:     key_state <= key_state; // other keys are ignored
			endcase
		end
	end

	// host joystick order differs from the core's button order
	always_comb begin
		sel_joy = joyswap ? joystick_1 : joystick_0;
		joy_buttons = '0;
		joy_buttons[btn_right]  = sel_joy[joy_right];
		joy_buttons[btn_left]   = sel_joy[joy_left];
		joy_buttons[btn_down]   = sel_joy[joy_down];
		joy_buttons[btn_up]     = sel_joy[joy_up];
		joy_buttons[btn_fire_a] = sel_joy[joy_fire_a];
		joy_buttons[btn_fire_b] = sel_joy[joy_fire_b];
		joy_buttons[btn_fire_c] = sel_joy[joy_fire_c];
		joy_buttons[btn_fire_d] = sel_joy[joy_fire_d];
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			player_buttons <= '0;
		end else begin
			player_buttons <= key_state | joy_buttons;
		end
	end

endmodule

//--- verilog/input_pkg.sv
package input_pkg;

	typedef logic [31:0] joy_word_t;
	typedef logic [7:0] key_code_t;
	typedef logic [7:0] player_buttons_t;

	// bit positions in the joystick word from the host, upper bits are unused
	localparam int joy_right  = 0;
	localparam int joy_left   = 1;
	localparam int joy_down   = 2;
	localparam int joy_up     = 3;
	localparam int joy_fire_a = 4;
	localparam int joy_fire_b = 5;
	localparam int joy_fire_c = 6;
	localparam int joy_fire_d = 7;

	// bit positions in the button vector that the core expects
	localparam int btn_right  = 0;
	localparam int btn_left   = 1;
	localparam int btn_down   = 2;
	localparam int btn_up     = 3;
	localparam int btn_fire_d = 4;
	localparam int btn_fire_c = 5;
	localparam int btn_fire_b = 6;
	localparam int btn_fire_a = 7;

endpackage

//--- verilog/mem_pkg.sv
`include "svision_defs.svh"

package mem_pkg;

	typedef logic [15:0] rom_word_t;
	typedef logic [`ROM_AW-1:0] rom_waddr_t;
	typedef logic [1:0] byte_en_t; // bit 0 low byte, bit 1 high byte

	localparam int rom_words = 2 ** `ROM_AW;

	localparam byte_en_t be_low  = 2'b01;
	localparam byte_en_t be_high = 2'b10;

endpackage

//--- verilog/rom_loader.sv
`timescale 1ns/1ps
`include "svision_defs.svh"

module rom_loader (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                ioctl_download,
	input  logic                ioctl_wr,
	input  logic [24:0]         ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	input  logic                menu_reset,
	input  logic                button_reset,
	output logic                mem_we,
	output mem_pkg::rom_waddr_t mem_waddr,
	output mem_pkg::byte_en_t   mem_be,
	output mem_pkg::rom_word_t  mem_wdata,
	output logic                rom_loaded,
	output logic                core_reset
);
	import mem_pkg::*;

	logic download_d;
	logic download_fall;
	logic write_hit;

	assign write_hit     = ioctl_download & ioctl_wr; // strobes outside a download are dropped
	assign download_fall = download_d & ~ioctl_download;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mem_we <= 1'b0;
		end else begin
			mem_we <= write_hit;
		end
	end

	// each byte becomes one word write with a single lane enabled
	always_ff @(posedge clk_sys) begin
		if (write_hit) begin
			mem_waddr <= ioctl_addr[`ROM_AW:1];
			mem_be    <= ioctl_addr[0] ? be_high : be_low;
			mem_wdata <= {ioctl_dout, ioctl_dout}; // the enable picks the lane
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			download_d <= 1'b0;
		end else begin
			download_d <= ioctl_download;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rom_loaded <= 1'b0;
		end else if (download_fall) begin
			rom_loaded <= 1'b1; // sticky until the next board reset
		end
	end

	// the core stays in reset until an image is in memory
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= menu_reset | button_reset | ~rom_loaded;
		end
	end

endmodule

//--- verilog/rom_store.sv
`timescale 1ns/1ps
`include "svision_defs.svh"

module rom_store (
	input  logic                clk_sys,
	input  logic                mem_we,
	input  mem_pkg::rom_waddr_t mem_waddr,
	input  mem_pkg::byte_en_t   mem_be,
	input  mem_pkg::rom_word_t  mem_wdata,
	input  logic [15:0]         cpu_rom_addr,
	output logic [7:0]          cpu_rom_data
);
	import mem_pkg::*;

	rom_word_t  mem [rom_words];
	rom_word_t  rd_word;
	rom_waddr_t rd_addr;
	logic       rd_odd;

	assign rd_addr = cpu_rom_addr[`ROM_AW:1]; // word index of the CPU byte address

	// only the enabled lanes change, the other byte of the word is kept
	always_ff @(posedge clk_sys) begin
		if (mem_we) begin
			if (mem_be[0]) begin
				mem[mem_waddr][7:0] <= mem_wdata[7:0];
			end
			if (mem_be[1]) begin
				mem[mem_waddr][15:8] <= mem_wdata[15:8];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		rd_word <= mem[rd_addr];
		rd_odd  <= cpu_rom_addr[0]; // travels with the word to pick the byte
	end

	assign cpu_rom_data = rd_odd ? rd_word[15:8] : rd_word[7:0];

endmodule

//--- verilog/sigma_delta_dac.sv
`timescale 1ns/1ps
`include "svision_defs.svh"

module sigma_delta_dac #(
	parameter int width = `DAC_BITS
) (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic [width-1:0] sample,
	output logic             dac_out
);

	logic [width:0] acc;
	logic [width:0] acc_next;

	// the carry of the previous sum is dropped before the next add
	assign acc_next = {1'b0, acc[width-1:0]} + {1'b0, sample};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

	// density of ones tracks sample / 2**width
	assign dac_out = acc[width];

endmodule

//--- verilog/svision_platform.sv
`timescale 1ns/1ps
`include "svision_defs.svh"

module svision_platform (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       ioctl_download,
	input  logic                       ioctl_wr,
	input  logic [24:0]                ioctl_addr,
	input  logic [7:0]                 ioctl_dout,
	input  logic                       menu_reset,
	input  logic                       button_reset,
	input  logic [15:0]                cpu_rom_addr,
	input  logic                       key_strobe,
	input  logic                       key_pressed,
	input  input_pkg::key_code_t       key_code,
	input  input_pkg::joy_word_t       joystick_0,
	input  input_pkg::joy_word_t       joystick_1,
	input  logic                       joyswap,
	input  logic [`DAC_BITS-1:0]       audio_ch1,
	input  logic [`DAC_BITS-1:0]       audio_ch2,
	output logic [7:0]                 cpu_rom_data,
	output logic                       rom_loaded,
	output logic                       core_reset,
	output input_pkg::player_buttons_t player_buttons,
	output logic                       audio_l,
	output logic                       audio_r
);
	import mem_pkg::*;

	logic       mem_we;
	rom_waddr_t mem_waddr;
	byte_en_t   mem_be;
	rom_word_t  mem_wdata;

	rom_loader loader (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.menu_reset     (menu_reset),
		.button_reset   (button_reset),
		.mem_we         (mem_we),
		.mem_waddr      (mem_waddr),
		.mem_be         (mem_be),
		.mem_wdata      (mem_wdata),
		.rom_loaded     (rom_loaded),
		.core_reset     (core_reset)
	);

	// block RAM stands in for the board SDRAM
	rom_store store (
		.clk_sys      (clk_sys),
		.mem_we       (mem_we),
		.mem_waddr    (mem_waddr),
		.mem_be       (mem_be),
		.mem_wdata    (mem_wdata),
		.cpu_rom_addr (cpu_rom_addr),
		.cpu_rom_data (cpu_rom_data)
	);

	input_mapper mapper (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.key_strobe     (key_strobe),
		.key_pressed    (key_pressed),
		.key_code       (key_code),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.joyswap        (joyswap),
		.player_buttons (player_buttons)
	);

	sigma_delta_dac #(.width(`DAC_BITS)) dac_l (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (audio_ch1),
		.dac_out (audio_l)
	);

	sigma_delta_dac #(.width(`DAC_BITS)) dac_r (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (audio_ch2),
		.dac_out (audio_r)
	);

endmodule
